/* shooter_top.f */
source/shooter_pkg.sv
source/frame_timer.sv
source/sprite_control.sv
source/sprite_datapath.sv
source/player_motion.sv
source/bullet_motion.sv
source/pixel_arbiter.sv
source/shooter_top.sv
verif/shooter_tb.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = shooter_tb
FILELIST  = shooter_top.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then \
		echo "Testbench reported failure"; \
		exit 1; \
	fi
	@grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verif/shooter_tb.sv */
`timescale 1ns/1ps

module shooter_tb import shooter_pkg::*; ();

  localparam int ROWS = 10;
  localparam int MAX_PIX = 32;
  localparam int FRAME_WAIT = 400;   // Cycles allowed for one player frame
  localparam int BULLET_Y0 = PLAYER_Y + BULLET_Y_OFFSET;

  // Columns are left, right, space, player frames and expected player x after the row
  int stim_table [ROWS][5] = '{
    '{1, 1, 1,   2,   3},
    '{0, 1, 1,   3,   2},   // Runs into the left bound
    '{1, 0, 1,   4,   6},
    '{1, 1, 0,   1,   6},   // Fire from x 6
    '{1, 0, 1,  20,  26},
    '{0, 0, 1,   4,  22},   // Left wins over right
    '{1, 1, 1,  40,  22},   // Bullet reaches the bottom in here
    '{1, 0, 1, 140, 156},   // Runs into the right bound
    '{0, 1, 1,   2, 154},
    '{1, 1, 0,   1, 154}
  };

  logic               clk = 1'b0;
  logic               resetn;
  logic [COLOR_W-1:0] color_in;
  logic               space;
  logic               left;
  logic               right;
  logic [X_W-1:0]     x_out;
  logic [Y_W-1:0]     y_out;
  logic [COLOR_W-1:0] color_out;
  logic               write_en;

  int errors = 0;
  int checks = 0;
  bit timed_out = 1'b0;
  int cycles = 0;
  bit seen_pixel = 1'b0;
  int burst_len = 0;
  int low_run = 2;
  int mid_gap = 0;   // Pixels seen before the load gap
  int pix_x [MAX_PIX];
  int pix_y [MAX_PIX];
  int pix_c [MAX_PIX];
  int player_frames = 0;
  int bullet_frames = 0;
  int bullet_ends = 0;
  int model_x = PLAYER_X_START;
  int drawn_x = PLAYER_X_START;   // Corner of the last player draw seen on the port
  bit launch_armed = 1'b0;
  int launch_x = 0;
  bit bullet_live = 1'b0;
  int bullet_x = 0;
  int bullet_y = 0;

  shooter_top UUT (
    .clk(clk), .resetn(resetn), .color_in(color_in), .space(space),
    .left(left), .right(right), .x_out(x_out), .y_out(y_out),
    .color_out(color_out), .write_en(write_en)
  );

  always #5 clk = ~clk;

  task automatic check(input string name, input int expected, input int actual);
    checks++;
    if (expected != actual) begin
      errors++;
      $display("error at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
    end
  endtask

  task automatic check_player_burst();
    int new_x;
    int corner;
    int i;
    new_x = model_x;
    if (!left && model_x > PLAYER_X_MIN) begin
      new_x = model_x - 1;
    end else if (!right && model_x < PLAYER_X_MAX) begin
      new_x = model_x + 1;
    end
    for (i = 0; i < 2 * PLAYER_W * PLAYER_H; i++) begin
      corner = (i < PLAYER_W * PLAYER_H) ? model_x : new_x;
      check("x_out", corner + (i % (PLAYER_W * PLAYER_H)) % PLAYER_W, pix_x[i]);
      check("y_out", PLAYER_Y + (i % (PLAYER_W * PLAYER_H)) / PLAYER_W, pix_y[i]);
      check("color_out", (i < PLAYER_W * PLAYER_H) ? COLOR_BLACK : color_in, pix_c[i]);
    end
    model_x = new_x;
    drawn_x = pix_x[PLAYER_W * PLAYER_H];
    player_frames++;
  endtask

  task automatic check_bullet_burst();
    int new_y;
    bit last;
    int i;
    if (!bullet_live) begin
      if (launch_armed) begin
        bullet_live = 1'b1;
        launch_armed = 1'b0;
        bullet_x = launch_x;
        bullet_y = BULLET_Y0;
      end else begin
        errors++;
        $display("bullet pixels at %0t with no bullet launched", $time);
      end
    end
    last = (bullet_y >= BULLET_Y_LAST);
    new_y = last ? bullet_y : bullet_y + 1;   // Last frame redraws in place in black
    for (i = 0; i < 2 * BULLET_H; i++) begin
      check("x_out", bullet_x, pix_x[i]);
      check("y_out", ((i < BULLET_H) ? bullet_y : new_y) + i % BULLET_H, pix_y[i]);
      check("color_out", (i < BULLET_H || last) ? COLOR_BLACK : BULLET_COLOR, pix_c[i]);
    end
    bullet_y = new_y;
    if (last) begin
      bullet_live = 1'b0;
      bullet_ends++;
    end
    bullet_frames++;
  endtask

  task automatic close_burst();
    if (burst_len == 2 * PLAYER_W * PLAYER_H && mid_gap == PLAYER_W * PLAYER_H) begin
      check_player_burst();
    end else if (burst_len == 2 * BULLET_H && mid_gap == BULLET_H) begin
      check_bullet_burst();
    end else begin
      errors++;
      $display("burst of %0d pixels with load gap after %0d at %0t is no sprite frame",
               burst_len, mid_gap, $time);
    end
    burst_len = 0;
    mid_gap = 0;
  endtask

  // A single idle cycle inside a burst is the load step
  always @(negedge clk) begin
    if (!resetn) begin
      check("write_en", 0, write_en);
    end else begin
      cycles++;
      if (write_en) begin
        if (!seen_pixel) begin
          seen_pixel = 1'b1;
          if (cycles <= PLAYER_PERIOD) begin
            errors++;
            $display("first pixel came only %0d cycles after reset", cycles);
          end
        end
        if (low_run == 1 && burst_len > 0) begin
          mid_gap = burst_len;
        end
        if (burst_len < MAX_PIX) begin
          pix_x[burst_len] = x_out;
          pix_y[burst_len] = y_out;
          pix_c[burst_len] = color_out;
        end
        burst_len++;
        low_run = 0;
      end else begin
        low_run++;
        if (low_run == 2 && burst_len > 0) begin
          close_burst();
        end
      end
    end
  end

  task automatic wait_player_frames(input int target, input int limit);
    int guard;
    guard = 0;
    while (player_frames < target && !timed_out) begin
      @(posedge clk);
      guard++;
      if (guard > limit) begin
        timed_out = 1'b1;
        $display("timeout: player frame %0d did not arrive within %0d cycles", target, limit);
      end
    end
  endtask

  initial begin
    int row;
    int target;
    void'($urandom(93));
    resetn = 1'b0;
    left = 1'b1;
    right = 1'b1;
    space = 1'b1;
    color_in = '0;
    repeat (16) @(posedge clk);
    resetn <= 1'b1;
    for (row = 0; row < ROWS && !timed_out; row++) begin
      left     <= (stim_table[row][0] != 0);
      right    <= (stim_table[row][1] != 0);
      space    <= (stim_table[row][2] != 0);
      color_in <= COLOR_W'($urandom % 8);
      if (stim_table[row][2] == 0 && !bullet_live && !launch_armed) begin
        launch_x = model_x;   // Bullet starts under the player as it stands now
        launch_armed = 1'b1;
      end
      target = player_frames + stim_table[row][3];
      wait_player_frames(target, FRAME_WAIT * stim_table[row][3]);
      check("player x", stim_table[row][4], drawn_x);
    end
    check("bullet ends", 1, bullet_ends);
    $display("checks %0d, errors %0d, timeout %0d, player frames %0d, bullet frames %0d",
             checks, errors, timed_out, player_frames, bullet_frames);
    if (errors == 0 && !timed_out) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* source/shooter_top.sv */
`timescale 1ns/1ps

module shooter_top import shooter_pkg::*; (
  input  logic               clk,
  input  logic               resetn,
  input  logic [COLOR_W-1:0] color_in,
  input  logic               space,
  input  logic               left,
  input  logic               right,
  output logic [X_W-1:0]     x_out,
  output logic [Y_W-1:0]     y_out,
  output logic [COLOR_W-1:0] color_out,
  output logic               write_en
);

  logic bus_idle;

  // Player side
  logic               player_tick;
  logic               player_req;
  logic               player_grant;
  logic               player_busy;
  logic               player_ld_next;
  logic               player_scan_load;
  logic               player_scan_step;
  logic               player_is_color;
  logic [X_W-1:0]     player_pos_x;
  logic [X_W-1:0]     player_pix_x;
  logic [Y_W-1:0]     player_pix_y;
  logic [COLOR_W-1:0] player_pix_color;

  // Bullet side
  logic               bullet_tick;
  logic               bullet_req;
  logic               bullet_grant;
  logic               bullet_busy;
  logic               bullet_ld_next;
  logic               bullet_scan_load;
  logic               bullet_scan_step;
  logic               bullet_is_color;
  logic               bullet_active;
  logic [X_W-1:0]     bullet_pos_x;
  logic [Y_W-1:0]     bullet_pos_y;
  logic [COLOR_W-1:0] bullet_color;
  logic [X_W-1:0]     bullet_pix_x;
  logic [Y_W-1:0]     bullet_pix_y;
  logic [COLOR_W-1:0] bullet_pix_color;

  frame_timer #(.PERIOD(PLAYER_PERIOD)) player_timer (
    .clk(clk), .resetn(resetn), .bus_idle(bus_idle), .clear(1'b0), .tick(player_tick)
  );

  sprite_control #(.PIXELS(PLAYER_W * PLAYER_H)) player_ctrl (
    .clk(clk), .resetn(resetn), .tick(player_tick), .grant(player_grant),
    .req(player_req), .busy(player_busy), .ld_next(player_ld_next),
    .scan_load(player_scan_load), .scan_step(player_scan_step), .is_color(player_is_color)
  );

  player_motion player_move (
    .clk(clk), .resetn(resetn), .ld_next(player_ld_next),
    .left(left), .right(right), .x(player_pos_x)
  );

  sprite_datapath #(.W(PLAYER_W)) player_dp (
    .clk(clk), .resetn(resetn), .x_in(player_pos_x), .y_in(PLAYER_Y),
    .scan_load(player_scan_load), .scan_step(player_scan_step),
    .is_color(player_is_color), .color_in(color_in),
    .x_out(player_pix_x), .y_out(player_pix_y), .color_out(player_pix_color)
  );

  frame_timer #(.PERIOD(BULLET_PERIOD)) bullet_timer (
    .clk(clk), .resetn(resetn), .bus_idle(bus_idle), .clear(!bullet_active),
    .tick(bullet_tick)
  );

  sprite_control #(.PIXELS(BULLET_W * BULLET_H)) bullet_ctrl (
    .clk(clk), .resetn(resetn), .tick(bullet_tick), .grant(bullet_grant),
    .req(bullet_req), .busy(bullet_busy), .ld_next(bullet_ld_next),
    .scan_load(bullet_scan_load), .scan_step(bullet_scan_step), .is_color(bullet_is_color)
  );

  bullet_motion bullet_move (
    .clk(clk), .resetn(resetn), .space(space), .player_x(player_pos_x),
    .ld_next(bullet_ld_next), .active(bullet_active),
    .x(bullet_pos_x), .y(bullet_pos_y), .color(bullet_color)
  );

  sprite_datapath #(.W(BULLET_W)) bullet_dp (
    .clk(clk), .resetn(resetn), .x_in(bullet_pos_x), .y_in(bullet_pos_y),
    .scan_load(bullet_scan_load), .scan_step(bullet_scan_step),
    .is_color(bullet_is_color), .color_in(bullet_color),
    .x_out(bullet_pix_x), .y_out(bullet_pix_y), .color_out(bullet_pix_color)
  );

  pixel_arbiter arbiter (
    .clk(clk), .resetn(resetn),
    .player_req(player_req), .player_busy(player_busy),
    .bullet_req(bullet_req), .bullet_busy(bullet_busy),
    .player_x(player_pix_x), .player_y(player_pix_y), .player_color(player_pix_color),
    .bullet_x(bullet_pix_x), .bullet_y(bullet_pix_y), .bullet_color(bullet_pix_color),
    .player_grant(player_grant), .bullet_grant(bullet_grant), .bus_idle(bus_idle),
    .x_out(x_out), .y_out(y_out), .color_out(color_out), .write_en(write_en)
  );

endmodule

/* source/pixel_arbiter.sv */
`timescale 1ns/1ps

module pixel_arbiter import shooter_pkg::*; (
  input  logic               clk,
  input  logic               resetn,
  input  logic               player_req,
  input  logic               player_busy,
  input  logic               bullet_req,
  input  logic               bullet_busy,
  input  logic [X_W-1:0]     player_x,
  input  logic [Y_W-1:0]     player_y,
  input  logic [COLOR_W-1:0] player_color,
  input  logic [X_W-1:0]     bullet_x,
  input  logic [Y_W-1:0]     bullet_y,
  input  logic [COLOR_W-1:0] bullet_color,
  output logic               player_grant,
  output logic               bullet_grant,
  output logic               bus_idle,
  output logic [X_W-1:0]     x_out,
  output logic [Y_W-1:0]     y_out,
  output logic [COLOR_W-1:0] color_out,
  output logic               write_en
);

  logic busy_q;
  logic mid_frame;   // Erase done, busy dropped once for the load step

  assign write_en = (player_grant && player_busy) || (bullet_grant && bullet_busy);
  assign bus_idle = !(player_grant || bullet_grant);

  always_ff @(posedge clk) begin
    if (!resetn) begin
      player_grant <= 1'b0;
      bullet_grant <= 1'b0;
      busy_q       <= 1'b0;
      mid_frame    <= 1'b0;
    end else begin
      busy_q <= write_en;
      if (bus_idle) begin
        player_grant <= player_req;                  // Player has priority
        bullet_grant <= bullet_req && !player_req;
      end else if (busy_q && !write_en) begin
        // Second fall of busy marks the end of the draw
        if (mid_frame) begin
          player_grant <= 1'b0;
          bullet_grant <= 1'b0;
          mid_frame    <= 1'b0;
        end else begin
          mid_frame <= 1'b1;
        end
      end
    end
  end

  assign x_out     = bullet_grant ? bullet_x : player_x;
  assign y_out     = bullet_grant ? bullet_y : player_y;
  assign color_out = bullet_grant ? bullet_color : player_color;

  a_one_grant: assert property (@(posedge clk) disable iff (!resetn)
    !(player_grant && bullet_grant));

endmodule

/* source/bullet_motion.sv */
`timescale 1ns/1ps

module bullet_motion import shooter_pkg::*; (
  input  logic               clk,
  input  logic               resetn,
  input  logic               space,
  input  logic [X_W-1:0]     player_x,
  input  logic               ld_next,
  output logic               active,
  output logic [X_W-1:0]     x,
  output logic [Y_W-1:0]     y,
  output logic [COLOR_W-1:0] color
);

  // Draw phase of the last frame still reads x and y after ld_next
  localparam int DRAIN = BULLET_W * BULLET_H;
  localparam int DRAIN_W = $clog2(DRAIN + 1);

  logic [DRAIN_W-1:0] drain;   // Cycles left before a new launch may move the bullet

  always_ff @(posedge clk) begin
    if (!resetn) begin
      active <= 1'b0;
      drain  <= '0;
      x      <= '0;
      y      <= '0;
    end else begin
      if (drain != '0) begin
        drain <= drain - 1'b1;
      end else if (!active && !space) begin
        active <= 1'b1;
        x      <= player_x;
        y      <= PLAYER_Y + BULLET_Y_OFFSET;
      end else if (active && ld_next) begin
        if (y < BULLET_Y_LAST) begin
          y <= y + 1'b1;
        end else begin
          active <= 1'b0;   // Bottom reached so this frame's draw erases it
          drain  <= DRAIN_W'(DRAIN);
        end
      end
    end
  end

  assign color = active ? BULLET_COLOR : COLOR_BLACK;

  a_y_last: assert property (@(posedge clk) disable iff (!resetn)
    y <= BULLET_Y_LAST);

endmodule

/* source/player_motion.sv */
`timescale 1ns/1ps

module player_motion import shooter_pkg::*; (
  input  logic           clk,
  input  logic           resetn,
  input  logic           ld_next,
  input  logic           left,
  input  logic           right,
  output logic [X_W-1:0] x
);

  logic step_left;
  logic step_right;

  // Active-low buttons where left wins when both are held
  assign step_left  = !left && (x > PLAYER_X_MIN);
  assign step_right = !right && (x < PLAYER_X_MAX);

  always_ff @(posedge clk) begin
    if (!resetn) begin
      x <= PLAYER_X_START;
    end else if (ld_next) begin
      if (step_left) begin
        x <= x - 1'b1;
      end else if (step_right) begin
        x <= x + 1'b1;
      end
    end
  end

  // Held buttons over many frames must still keep the player on screen
  a_x_bounds: assert property (@(posedge clk) disable iff (!resetn)
    (x >= PLAYER_X_MIN) && (x <= PLAYER_X_MAX));

endmodule

/* source/sprite_datapath.sv */
`timescale 1ns/1ps

module sprite_datapath import shooter_pkg::*; #(
  parameter int W = 1
) (
  input  logic               clk,
  input  logic               resetn,
  input  logic [X_W-1:0]     x_in,
  input  logic [Y_W-1:0]     y_in,
  input  logic               scan_load,
  input  logic               scan_step,
  input  logic               is_color,
  input  logic [COLOR_W-1:0] color_in,
  output logic [X_W-1:0]     x_out,
  output logic [Y_W-1:0]     y_out,
  output logic [COLOR_W-1:0] color_out
);

  localparam logic [X_W-1:0] X_SPAN = X_W'(W - 1);

  logic [X_W-1:0] px;
  logic [Y_W-1:0] py;
  logic [X_W-1:0] cur_x;
  logic [Y_W-1:0] cur_y;

  // First pixel of a scan comes straight from the corner
  assign cur_x = scan_load ? x_in : px;
  assign cur_y = scan_load ? y_in : py;

  // Row-major walk, x fastest
  always_ff @(posedge clk) begin
    if (!resetn) begin
      px <= '0;
      py <= '0;
    end else if (scan_step) begin
      if (cur_x == x_in + X_SPAN) begin   // End of row wraps to the left edge
        px <= x_in;
        py <= cur_y + 1'b1;
      end else begin
        px <= cur_x + 1'b1;
        py <= cur_y;
      end
    end
  end

  assign x_out     = cur_x;
  assign y_out     = cur_y;
  assign color_out = is_color ? color_in : COLOR_BLACK;

endmodule

/* source/sprite_control.sv */
`timescale 1ns/1ps

module sprite_control import shooter_pkg::*; #(
  parameter int PIXELS = 12
) (
  input  logic clk,
  input  logic resetn,
  input  logic tick,
  input  logic grant,
  output logic req,
  output logic busy,
  output logic ld_next,
  output logic scan_load,
  output logic scan_step,
  output logic is_color
);

  localparam int STEP_W = $clog2(PIXELS + 1);
  localparam logic [STEP_W-1:0] STEP_LAST = STEP_W'(PIXELS - 1);

  sprite_state_t state;
  logic pending;                    // A tick arrived and no frame has started for it yet
  logic [STEP_W-1:0] step;          // Pixel index inside the current scan
  logic scan_end;

  assign scan_end = (step == STEP_LAST);

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state   <= S_WAIT;
      pending <= 1'b0;
      step    <= '0;
    end else begin
      if (tick) begin
        pending <= 1'b1;
      end
      case (state)
        S_WAIT: begin
          step <= '0;
          // Grant is held one cycle past the frame, so check pending too
          if (grant && pending) begin
            pending <= 1'b0;
            state   <= S_ERASE;
          end
        end
        S_ERASE: begin
          if (scan_end) begin
            step  <= '0;
            state <= S_LOAD;
          end else begin
            step <= step + 1'b1;
          end
        end
        S_LOAD: begin
          state <= S_DRAW;           // Motion module moves the sprite here
        end
        S_DRAW: begin
          if (scan_end) begin
            step  <= '0;
            state <= S_WAIT;
          end else begin
            step <= step + 1'b1;
          end
        end
        default: state <= S_WAIT;
      endcase
    end
  end

  assign req       = (state == S_WAIT) && pending;
  assign busy      = (state == S_ERASE) || (state == S_DRAW);   // One pixel per cycle
  assign ld_next   = (state == S_LOAD);
  assign scan_step = busy;
  assign scan_load = busy && (step == '0);   // Corner of the block on the first pixel
  assign is_color  = (state == S_DRAW);

  // No pixel leaves unless the arbiter still holds the grant
  a_busy_granted: assert property (@(posedge clk) disable iff (!resetn)
    busy |-> grant);

  // Position update happens once per frame
  a_ld_next_pulse: assert property (@(posedge clk) disable iff (!resetn)
    ld_next |=> !ld_next);

endmodule

/* source/frame_timer.sv */
`timescale 1ns/1ps

module frame_timer import shooter_pkg::*; #(
  parameter int PERIOD = 16
) (
  input  logic clk,
  input  logic resetn,
  input  logic bus_idle,
  input  logic clear,
  output logic tick
);

  localparam logic [TIMER_W-1:0] COUNT_LAST = TIMER_W'(PERIOD - 1);

  logic [TIMER_W-1:0] count;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      count <= '0;
      tick  <= 1'b0;
    end else begin
      tick <= 1'b0;
      if (clear) begin
        count <= '0;
      end else if (bus_idle) begin   // Time only passes while nobody draws
        if (count == COUNT_LAST) begin
          count <= '0;
          tick  <= 1'b1;
        end else begin
          count <= count + 1'b1;
        end
      end
    end
  end

endmodule

/* source/shooter_pkg.sv */
package shooter_pkg;

  // Coordinate and colour widths
  localparam int X_W = 8;
  localparam int Y_W = 7;
  localparam int COLOR_W = 3;

  localparam logic [COLOR_W-1:0] COLOR_BLACK = COLOR_W'(0);   // Erase colour
  localparam logic [COLOR_W-1:0] BULLET_COLOR = COLOR_W'(1);

  // Visible area
  localparam int SCREEN_W = 160;
  localparam int SCREEN_H = 120;

  // Block sizes in pixels
  localparam int PLAYER_W = 4;
  localparam int PLAYER_H = 3;
  localparam int BULLET_W = 1;
  localparam int BULLET_H = 2;

  // Player sits on a fixed row and slides in x only
  localparam logic [X_W-1:0] PLAYER_X_START = X_W'(3);
  localparam logic [Y_W-1:0] PLAYER_Y = Y_W'(3);
  localparam logic [X_W-1:0] PLAYER_X_MIN = X_W'(2);
  localparam logic [X_W-1:0] PLAYER_X_MAX = X_W'(SCREEN_W - PLAYER_W);

  // Bullet starts a few rows under the player and falls to the bottom edge
  localparam logic [Y_W-1:0] BULLET_Y_OFFSET = Y_W'(4);
  localparam logic [Y_W-1:0] BULLET_Y_LAST = Y_W'(SCREEN_H - BULLET_H);

  // Idle bus cycles between redraws
  localparam int PLAYER_PERIOD = 40;
  localparam int BULLET_PERIOD = 16;
  localparam int TIMER_W = 8;

  // Per-sprite redraw sequence
  typedef enum logic [1:0] {
    S_WAIT,
    S_ERASE,
    S_LOAD,
    S_DRAW
  } sprite_state_t;

endpackage
